// File: rtl/conv_engine_top.sv
`timescale 1ns/1ps

module conv_engine_top #(
  parameter int UNITS   = 4,
  parameter int MEMBERS = 3
) (
  input  logic                                          aclk,
  input  logic                                          arst_n,
  input  logic                                          s_valid,
  output logic                                          s_ready,
  input  conv_num_pkg::pixel_t  [UNITS-1:0]             s_pixels,
  input  conv_num_pkg::weight_t [MEMBERS-1:0]           s_weights,
  input  logic                                          s_last,
  input  conv_stream_pkg::user_t                        s_user,
  output logic                                          m_valid,
  input  logic                                          m_ready,
  output conv_num_pkg::acc_t    [MEMBERS-1:0][UNITS-1:0] m_data,
  output conv_stream_pkg::user_t                        m_user,
  output logic                                          m_last
);
  import conv_num_pkg::*;
  import conv_stream_pkg::*;

  win_ctl_t                      ctl;
  pixel_t  [UNITS-1:0]           pixels;
  weight_t [MEMBERS-1:0]         weights;
  user_t                         res_user;
  acc_t    [MEMBERS-1:0][UNITS-1:0] acc_all;
  logic                          done;
  logic                          en;     // Clock enable from the output slice

  assign s_ready = en;

  conv_feed_stage #(.UNITS(UNITS), .MEMBERS(MEMBERS)) u_conv_feed_stage (
    .aclk     (aclk),
    .arst_n   (arst_n),
    .en       (en),
    .s_valid  (s_valid),
    .s_last   (s_last),
    .s_pixels (s_pixels),
    .s_weights(s_weights),
    .s_user   (s_user),
    .ctl      (ctl),
    .pixels   (pixels),
    .weights  (weights),
    .res_user (res_user)
  );

  for (genvar m = 0; m < MEMBERS; m++) begin : gen_member
    if (m == 0) begin : gen_lead  // Members run in lockstep, one done is enough
      conv_member #(.UNITS(UNITS)) u_conv_member (
        .aclk(aclk), .arst_n(arst_n), .en(en), .ctl(ctl), .pixels(pixels),
        .weight(weights[m]), .acc(acc_all[m]), .done(done)
      );
    end else begin : gen_rest
      conv_member #(.UNITS(UNITS)) u_conv_member (
        .aclk(aclk), .arst_n(arst_n), .en(en), .ctl(ctl), .pixels(pixels),
        .weight(weights[m]), .acc(acc_all[m]), .done()
      );
    end
  end

  conv_out_slice #(.UNITS(UNITS), .MEMBERS(MEMBERS)) u_conv_out_slice (
    .aclk   (aclk),
    .arst_n (arst_n),
    .done   (done),
    .acc_all(acc_all),
    .user   (res_user),
    .en     (en),
    .m_valid(m_valid),
    .m_ready(m_ready),
    .m_data (m_data),
    .m_user (m_user),
    .m_last (m_last)
  );

endmodule

// File: rtl/conv_feed_stage.sv
`timescale 1ns/1ps

module conv_feed_stage #(
  parameter int UNITS   = 4,
  parameter int MEMBERS = 3
) (
  input  logic                                  aclk,
  input  logic                                  arst_n,
  input  logic                                  en,
  input  logic                                  s_valid,
  input  logic                                  s_last,
  input  conv_num_pkg::pixel_t  [UNITS-1:0]     s_pixels,
  input  conv_num_pkg::weight_t [MEMBERS-1:0]   s_weights,
  input  conv_stream_pkg::user_t                s_user,
  output conv_stream_pkg::win_ctl_t             ctl,
  output conv_num_pkg::pixel_t  [UNITS-1:0]     pixels,
  output conv_num_pkg::weight_t [MEMBERS-1:0]   weights,
  output conv_stream_pkg::user_t                res_user
);
  import conv_stream_pkg::*;

  logic  step_q;
  logic  first_q;
  logic  last_q;
  logic  after_last;  // Previous accepted beat closed a window
  user_t user_q;

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      step_q     <= 1'b0;
      first_q    <= 1'b0;
      last_q     <= 1'b0;
      after_last <= 1'b1;
    end else if (en) begin
      step_q  <= s_valid;
      first_q <= s_valid & after_last;
      last_q  <= s_valid & s_last;
      if (s_valid) begin
        after_last <= s_last;
      end
    end
  end

  // Operands of the accepted beat
  always_ff @(posedge aclk) begin
    if (en && s_valid) begin
      pixels  <= s_pixels;
      weights <= s_weights;
      user_q  <= s_user;
    end
  end

  // Tag follows the window into the fold cycle
  always_ff @(posedge aclk) begin
    if (en && step_q && last_q) begin
      res_user <= user_q;
    end
  end

  assign ctl = '{step: step_q, first: first_q, last: last_q, user: user_q};

endmodule

// File: rtl/conv_member.sv
`timescale 1ns/1ps

module conv_member #(
  parameter int UNITS = 4
) (
  input  logic                                aclk,
  input  logic                                arst_n,
  input  logic                                en,
  input  conv_stream_pkg::win_ctl_t           ctl,
  input  conv_num_pkg::pixel_t  [UNITS-1:0]   pixels,
  input  conv_num_pkg::weight_t               weight,
  output conv_num_pkg::acc_t    [UNITS-1:0]   acc,
  output logic                                done
);
  import conv_num_pkg::*;

  prod_t [UNITS-1:0] prod;
  acc_t  [UNITS-1:0] sum;   // Shadow sums of the open window
  acc_t  [UNITS-1:0] fold;  // Sums including this step

  // One MAC lane per unit, all sharing the member's weight
  always_comb begin
    for (int u = 0; u < UNITS; u++) begin
      prod[u] = pixels[u] * weight;
      if (ctl.first) begin
        fold[u] = acc_t'(prod[u]);  // Sign extended load
      end else begin
        fold[u] = sum[u] + prod[u];
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (en && ctl.step) begin
      sum <= fold;
      if (ctl.last) begin
        acc <= fold;  // Held until the next window closes
      end
    end
  end

  // Result ready for the slice in the cycle after the last step
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      done <= 1'b0;
    end else if (en) begin
      done <= ctl.step & ctl.last;
    end
  end

endmodule

// File: rtl/conv_num_pkg.sv
package conv_num_pkg;

  // Element widths, also used to flatten packed arrays
  localparam int PIXEL_W  = 8;
  localparam int WEIGHT_W = 8;
  localparam int PROD_W   = PIXEL_W + WEIGHT_W;
  localparam int ACC_W    = 20;  // 16 products of 8x8 bits fit with headroom

  // Signed pixel value of one unit
  typedef logic signed [PIXEL_W-1:0] pixel_t;

  // Signed weight of one kernel member
  typedef logic signed [WEIGHT_W-1:0] weight_t;

  // Full precision product of a pixel and a weight
  typedef logic signed [PROD_W-1:0] prod_t;

  // Running sum over one kernel window
  typedef logic signed [ACC_W-1:0] acc_t;

endpackage

// File: rtl/conv_out_slice.sv
`timescale 1ns/1ps

module conv_out_slice #(
  parameter int UNITS   = 4,
  parameter int MEMBERS = 3
) (
  input  logic                                                aclk,
  input  logic                                                arst_n,
  input  logic                                                done,
  input  conv_num_pkg::acc_t [MEMBERS-1:0][UNITS-1:0]         acc_all,
  input  conv_stream_pkg::user_t                              user,
  output logic                                                en,
  output logic                                                m_valid,
  input  logic                                                m_ready,
  output conv_num_pkg::acc_t [MEMBERS-1:0][UNITS-1:0]         m_data,
  output conv_stream_pkg::user_t                              m_user,
  output logic                                                m_last
);
  import conv_num_pkg::*;
  import conv_stream_pkg::*;

  logic [1:0] count;       // Occupied entries, 0 to 2
  logic [1:0] count_next;
  logic       en_q;
  logic       push;
  logic       pop;

  acc_t [MEMBERS-1:0][UNITS-1:0] prim_data;
  acc_t [MEMBERS-1:0][UNITS-1:0] spare_data;
  res_ctl_t                      prim_ctl;
  res_ctl_t                      spare_ctl;
  res_ctl_t                      in_ctl;

  assign in_ctl = '{last: 1'b1, user: user};  // Every result beat closes its window

  assign push = done & en_q;
  assign pop  = m_valid & m_ready;

  always_comb begin
    count_next = count;
    if (push && !pop) begin
      count_next = count + 2'd1;
    end else if (pop && !push) begin
      count_next = count - 2'd1;
    end
  end

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      count <= 2'd0;
      en_q  <= 1'b1;
    end else begin
      count <= count_next;
      en_q  <= (count_next != 2'd2);  // Engine runs while an entry is free
    end
  end

  always_ff @(posedge aclk) begin
    if (pop && count == 2'd2) begin
      prim_data <= spare_data;  // Spare moves up, order kept
      prim_ctl  <= spare_ctl;
    end else if (push && (count == 2'd0 || pop)) begin
      prim_data <= acc_all;
      prim_ctl  <= in_ctl;
    end
    if (push && !pop && count == 2'd1) begin
      spare_data <= acc_all;
      spare_ctl  <= in_ctl;
    end
  end

  assign en      = en_q;
  assign m_valid = (count != 2'd0);
  assign m_data  = prim_data;
  assign m_user  = prim_ctl.user;
  assign m_last  = prim_ctl.last;

endmodule

// File: rtl/conv_stream_pkg.sv
package conv_stream_pkg;

  localparam int USER_W = 6;

  // Tag that travels with a kernel window
  typedef logic [USER_W-1:0] user_t;

  // Window control broadcast by the feed stage
  typedef struct packed {
    logic  step;   // Operands valid this cycle
    logic  first;  // First beat of a window
    logic  last;   // Last beat of a window
    user_t user;
  } win_ctl_t;

  // Sideband of one result beat
  typedef struct packed {
    logic  last;
    user_t user;
  } res_ctl_t;

endpackage

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module conv_engine_tb \
  -f sim.f -o conv_engine_sim || exit 1
./obj_dir/conv_engine_sim | tee /dev/stderr | grep -qx "NO ERRORS" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// File: sim.f
rtl/conv_num_pkg.sv
rtl/conv_stream_pkg.sv
rtl/conv_feed_stage.sv
rtl/conv_member.sv
rtl/conv_out_slice.sv
rtl/conv_engine_top.sv
tests/conv_engine_asserts.sv
tests/conv_engine_tb.sv

// File: tests/conv_engine_asserts.sv
`timescale 1ns/1ps

module conv_engine_asserts #(
  parameter int UNITS   = 4,
  parameter int MEMBERS = 3
) (
  input logic                                          aclk,
  input logic                                          arst_n,
  input logic                                          s_valid,
  input logic                                          s_ready,
  input logic                                          m_valid,
  input logic                                          m_ready,
  input conv_num_pkg::acc_t [MEMBERS-1:0][UNITS-1:0]   m_data,
  input conv_stream_pkg::user_t                        m_user,
  input conv_num_pkg::acc_t [MEMBERS-1:0][UNITS-1:0]   acc_all,
  input logic                                          done
);

  // Result held while the sink stalls
  hold_under_stall: assert property (@(posedge aclk) disable iff (!arst_n)
    m_valid && !m_ready |=> m_valid && $stable(m_data) && $stable(m_user))
    else $error("Output beat changed while m_ready was low");

  no_valid_in_reset: assert property (@(posedge aclk) !arst_n |-> !m_valid)
    else $error("m_valid high during reset");

  // A beat offered to a stalled engine leaves the member sums alone
  stall_ignores_input: assert property (@(posedge aclk) disable iff (!arst_n)
    s_valid && !s_ready |=> $stable(acc_all) && $stable(done))
    else $error("Input beat disturbed member sums while s_ready was low");

endmodule

// File: tests/conv_engine_tb.sv
`timescale 1ns/1ps

module conv_engine_tb;
  import conv_num_pkg::*;
  import conv_stream_pkg::*;

  localparam int UNITS     = 4;
  localparam int MEMBERS   = 3;
  localparam int MAX_WIN   = 16;
  localparam int N_WIN     = 40;
  localparam int N_GAP_WIN = 20;
  localparam int CLK_NS    = 8;
  localparam int DATA_W    = MEMBERS * UNITS * ACC_W;

  typedef logic [DATA_W-1:0] data_t;  // Member-major, like m_data

  typedef struct packed {
    user_t user;
    data_t data;
  } exp_beat_t;

  logic                             aclk = 1'b0;
  logic                             arst_n;
  logic                             s_valid;
  logic                             s_ready;
  pixel_t  [UNITS-1:0]              s_pixels;
  weight_t [MEMBERS-1:0]            s_weights;
  logic                             s_last;
  user_t                            s_user;
  logic                             m_valid;
  logic                             m_ready;
  acc_t    [MEMBERS-1:0][UNITS-1:0] m_data;
  user_t                            m_user;
  logic                             m_last;

  pixel_t    win_pix [MAX_WIN][UNITS];    // Operands of the window being sent
  weight_t   win_wts [MAX_WIN][MEMBERS];
  exp_beat_t expected_q[$];
  exp_beat_t front;
  string     test_name = "reset";
  integer    seed = 16;
  integer    ready_seed = 16;
  int        ready_draw;
  int        errors = 0;
  int        beats_sent = 0;
  int        n;
  logic      bp_on = 1'b0;
  logic      saw_stall = 1'b0;

  conv_engine_top #(.UNITS(UNITS), .MEMBERS(MEMBERS)) u_conv_engine_top (.*);

  bind conv_engine_top conv_engine_asserts #(.UNITS(UNITS), .MEMBERS(MEMBERS))
    u_conv_engine_asserts (.aclk(aclk), .arst_n(arst_n), .s_valid(s_valid), .s_ready(s_ready),
      .m_valid(m_valid), .m_ready(m_ready), .m_data(m_data), .m_user(m_user),
      .acc_all(acc_all), .done(done));

  always #(CLK_NS / 2) aclk = ~aclk;

  // Expected sums of one window, sign extended products
  function automatic data_t conv_ref(input int len);
    data_t res;
    int    sum;
    res = '0;
    for (int m = 0; m < MEMBERS; m++) begin
      for (int u = 0; u < UNITS; u++) begin
        sum = 0;
        for (int b = 0; b < len; b++) begin
          sum = sum + int'(win_pix[b][u]) * int'(win_wts[b][m]);
        end
        res[(m * UNITS + u) * ACC_W +: ACC_W] = sum[ACC_W-1:0];
      end
    end
    return res;
  endfunction

  task automatic report(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  task automatic fill_random(input int len);
    for (int b = 0; b < len; b++) begin
      for (int u = 0; u < UNITS; u++) begin
        win_pix[b][u] = pixel_t'($random(seed));
      end
      for (int m = 0; m < MEMBERS; m++) begin
        win_wts[b][m] = weight_t'($random(seed));
      end
    end
  endtask

  // Starts and ends 1 ns after a rising edge
  task automatic send_loaded(input int len, input int gap_max, input user_t tag);
    exp_beat_t beat;
    int        gap;
    logic      ready_seen;
    for (int b = 0; b < len; b++) begin
      gap = (gap_max > 0) ? int'({$random(seed)} % (gap_max + 1)) : 0;
      repeat (gap) begin
        @(posedge aclk);
        #1;
      end
      for (int u = 0; u < UNITS; u++) begin
        s_pixels[u] = win_pix[b][u];
      end
      for (int m = 0; m < MEMBERS; m++) begin
        s_weights[m] = win_wts[b][m];
      end
      s_user  = tag;
      s_last  = (b == len - 1);
      s_valid = 1'b1;
      beats_sent++;
      do begin
        @(negedge aclk);
        ready_seen = s_ready;
        @(posedge aclk);
      end while (!ready_seen);
      #1;
      s_valid = 1'b0;
      s_last  = 1'b0;
    end
    beat.user = tag;
    beat.data = conv_ref(len);
    expected_q.push_back(beat);
  endtask

  task automatic send_random(input int gap_max);
    int    len;
    user_t tag;
    len = 1 + int'({$random(seed)} % MAX_WIN);
    tag = user_t'($random(seed));
    fill_random(len);
    send_loaded(len, gap_max, tag);
  endtask

  task automatic drain(input int max_cycles);
    int waited;
    waited = 0;
    while (expected_q.size() != 0 && waited < max_cycles) begin
      @(posedge aclk);
      waited++;
    end
    if (expected_q.size() != 0) begin
      report($sformatf("Missing results in %s, %0d windows never came out", test_name,
                       expected_q.size()));
      expected_q.delete();
    end
    repeat (4) @(posedge aclk);
    #1;
  endtask

  // Toggled mid-cycle so the ready process never races it
  task automatic set_backpressure(input logic on);
    @(negedge aclk);
    bp_on = on;
    @(posedge aclk);
    #1;
  endtask

  always @(posedge aclk) begin
    #1;
    ready_draw = $random(ready_seed);
    m_ready    = bp_on ? ready_draw[0] : 1'b1;
  end

  // Scoreboard, sampled mid-cycle where outputs are stable
  always @(negedge aclk) begin
    if (arst_n && m_valid && m_ready) begin
      if (expected_q.size() == 0) begin
        report($sformatf("Unexpected output beat in %s with user %0d", test_name, m_user));
      end else begin
        front = expected_q.pop_front();
        if (m_data !== front.data)
          report($sformatf("Mismatch %s expected %h actual %h", test_name, front.data, m_data));
        if (m_user !== front.user)
          report($sformatf("Mismatch %s expected user %0d actual %0d", test_name, front.user,
                           m_user));
        if (m_last !== 1'b1)
          report($sformatf("Mismatch %s expected last 1 actual %b", test_name, m_last));
      end
    end
    if (arst_n && !s_ready) begin
      saw_stall = 1'b1;
      if (!m_valid) report($sformatf("s_ready low in %s with no result held", test_name));
    end
  end

  initial begin
    arst_n    = 1'b0;
    s_valid   = 1'b0;
    s_last    = 1'b0;
    s_pixels  = '0;
    s_weights = '0;
    s_user    = '0;
    m_ready   = 1'b1;
    repeat (8) begin
      @(negedge aclk);
      if (m_valid !== 1'b0 || s_ready !== 1'b1) report("Wrong m_valid or s_ready during reset");
    end
    @(posedge aclk);
    #1;
    arst_n = 1'b1;
    @(negedge aclk);
    if (m_valid !== 1'b0 || s_ready !== 1'b1) report("Wrong m_valid or s_ready after reset");
    @(posedge aclk);
    #1;

    test_name = "single_beat";
    win_pix[0] = '{pixel_t'(-128), pixel_t'(127), pixel_t'(-1), pixel_t'(5)};
    win_wts[0] = '{weight_t'(-128), weight_t'(127), weight_t'(-3)};
    send_loaded(1, 0, user_t'(6'h2a));
    drain(100);

    test_name = "multi_beat";
    seed = 16;
    repeat (N_WIN) send_random(0);
    drain(100);

    test_name = "back_pressure";
    seed = 16;  // Same traffic again
    saw_stall = 1'b0;
    set_backpressure(1'b1);
    repeat (N_WIN) send_random(0);
    drain(400);
    set_backpressure(1'b0);
    if (!saw_stall) report("s_ready never fell under back-pressure");

    test_name = "latency";
    fill_random(2);
    send_loaded(2, 0, user_t'(6'h11));
    n = 0;
    do begin
      @(negedge aclk);
      n++;
    end while (!m_valid && n < 10);
    if (n - 1 != 2) report($sformatf("Mismatch %s expected %0d actual %0d", test_name, 2, n - 1));
    drain(100);

    test_name = "input_gaps";
    repeat (N_GAP_WIN) send_random(3);
    drain(100);

    $display("Run complete with %0d errors", errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // Budget of four clocks per beat sent plus a fixed margin
  initial begin
    do begin
      @(posedge aclk);
    end while ($time <= (longint'(beats_sent) + 50) * CLK_NS * 4);
    errors++;
    $display("Timeout in %s after %0d beats sent", test_name, beats_sent);
    $display("Run complete with %0d errors", errors);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule
